// ==== src/next186_cfg.svh ====
// build constants; the BIOS buffer depth must stay 64 because the ioctl byte index is 7 bits
`ifndef NEXT186_CFG_SVH
`define NEXT186_CFG_SVH

// core clock in MHz
`define NEXT_CPU_MHZ 50

// FM synth enable, 3.58 MHz out of NEXT_CPU_MHZ * 100
`define NEXT_OPL2_INC 358

// audio sample enable, counted against NEXT_CPU_MHZ * 1e6
`define NEXT_AUDIO_RATE 44100

// words held by the BIOS download buffer
`define NEXT_BIOS_DEPTH 64

// words the consumer can take after reset
`define NEXT_BIOS_CREDITS 4

`endif

// ==== src/setup_pkg.sv ====
// settings, decoded setup and joystick types; only status bits 0, 2..6 and 8 carry meaning
`default_nettype none

package setup_pkg;

	// user settings word as sent by the OSD
	typedef struct packed {
		logic [6:0] rsvd_hi;
		logic       joy_swap;
		logic       rsvd_7;
		logic [1:0] isa_wait;
		logic [2:0] speed;
		logic       rsvd_1;
		logic       reset_req;
	} status_t;

	// decoded setup handed to the core
	typedef struct packed {
		logic [4:0] cpu_speed;
		logic [7:0] wait_states;
		logic       joy_swap;
	} setup_t;

	// two joysticks, buttons active high
	// an fields carry signed X in the high byte, signed Y in the low byte
	typedef struct packed {
		logic [3:0]  btn0;
		logic [3:0]  btn1;
		logic [15:0] an0;
		logic [15:0] an1;
	} joy_in_t;

endpackage

`default_nettype wire

// ==== src/xfer_pkg.sv ====
// BIOS transfer types; the byte index covers one 128-byte buffer pass and wraps after it
`default_nettype none

package xfer_pkg;

	// byte stream from the download controller
	typedef struct packed {
		logic       download;
		logic       wr;
		logic [6:0] addr;
		logic [7:0] data;
	} ioctl_t;

	// odd address byte high, even address byte low
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} bios_bytes_t;

	// one BIOS word, summed as a word and assembled as bytes
	typedef union packed {
		logic [15:0] word;
		bios_bytes_t bytes;
	} bios_word_u;

	// word toward the core, valid for one cycle per word
	typedef struct packed {
		logic       valid;
		logic [13:0] addr;
		bios_word_u data;
	} bios_out_t;

endpackage

`default_nettype wire

// ==== src/setup_ctrl.sv ====
// settings decode and core reset; reset stays asserted until the BIOS has been loaded once
`timescale 1ns/1ps
`default_nettype none

module setup_ctrl
	import setup_pkg::*;
(
	input  wire     clk_cpu,
	input  wire     reset_i,
	input  status_t status_i,
	input  wire     loaded_i,
	output setup_t  setup_o,
	output logic    sys_reset_o
);

	setup_t setup_d;

	always_comb begin
		setup_d.joy_swap = status_i.joy_swap;

		// divider minus one, so /2 gives 1 and /32 gives 31
		case (status_i.speed)
			3'd1: setup_d.cpu_speed = 5'd1;
			3'd2: setup_d.cpu_speed = 5'd2;
			3'd3: setup_d.cpu_speed = 5'd3;
			3'd4: setup_d.cpu_speed = 5'd7;
			3'd5: setup_d.cpu_speed = 5'd15;
			3'd6: setup_d.cpu_speed = 5'd31;
			default: setup_d.cpu_speed = 5'd0;
		endcase

		// ISA wait in cpu cycles, roughly 1 to 4 us
		case (status_i.isa_wait)
			2'd0: setup_d.wait_states = 8'd50;
			2'd1: setup_d.wait_states = 8'd100;
			2'd2: setup_d.wait_states = 8'd166;
			default: setup_d.wait_states = 8'd200;
		endcase
	end

	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			setup_o <= '{cpu_speed: 5'd0, wait_states: 8'd50, joy_swap: 1'b0};
		end else begin
			setup_o <= setup_d;
		end
	end

	// core held in reset until the BIOS is in place
	always_ff @(posedge clk_cpu) begin
		sys_reset_o <= reset_i | status_i.reset_req | ~loaded_i;
	end

endmodule

`default_nettype wire

// ==== src/bios_loader.sv ====
// BIOS byte-to-word buffer; the source must not run more than 64 words ahead, overrun is not caught
`timescale 1ns/1ps
`default_nettype none

`include "next186_cfg.svh"

module bios_loader
	import xfer_pkg::*;
(
	input  wire         clk_cpu,
	input  wire         reset_i,
	input  ioctl_t      ioctl_i,
	input  wire         bios_credit_i,
	output bios_out_t   bios_o,
	output logic [15:0] bios_checksum_o,
	output logic        loaded_o
);

	localparam int AW = $clog2(`NEXT_BIOS_DEPTH);
	localparam int PW = AW + 1;
	localparam int CW = $clog2(`NEXT_BIOS_CREDITS + 1);

	bios_word_u  mem [`NEXT_BIOS_DEPTH];
	bios_word_u  wr_word;
	logic [7:0]  lo_byte;
	logic        dl_q;
	logic [PW-1:0] wr_ptr;
	logic [13:0] word_addr;
	logic [CW-1:0] credits;
	logic        dl_rise;
	logic        dl_fall;
	logic        even_wr;
	logic        odd_wr;
	logic        send;

	assign dl_rise = ioctl_i.download & ~dl_q;
	assign dl_fall = ~ioctl_i.download & dl_q;
	assign even_wr = ioctl_i.download & ioctl_i.wr & ~ioctl_i.addr[0];
	assign odd_wr  = ioctl_i.download & ioctl_i.wr & ioctl_i.addr[0];

	// read pointer is the low part of the word address
	assign send = ~dl_rise & (wr_ptr != word_addr[PW-1:0]) & (credits != '0);

	always_comb begin
		wr_word.bytes.hi = ioctl_i.data;
		wr_word.bytes.lo = lo_byte;
	end

	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			dl_q            <= 1'b0;
			wr_ptr          <= '0;
			word_addr       <= '0;
			credits         <= CW'(`NEXT_BIOS_CREDITS);
			bios_o.valid    <= 1'b0;
			bios_checksum_o <= '0;
			loaded_o        <= 1'b0;
		end else begin
			dl_q         <= ioctl_i.download;
			bios_o.valid <= send;
			wr_ptr       <= (dl_rise ? '0 : wr_ptr) + PW'(odd_wr);

			if (dl_rise) begin
				word_addr <= '0;
			end else if (send) begin
				word_addr <= word_addr + 14'd1;
			end

			// return and send together leave the count alone
			if (bios_credit_i & ~send) begin
				credits <= credits + 1'b1;
			end else if (send & ~bios_credit_i) begin
				credits <= credits - 1'b1;
			end

			if (dl_rise) begin
				bios_checksum_o <= '0;
			end else if (bios_o.valid) begin
				bios_checksum_o <= bios_checksum_o + bios_o.data.word;
			end

			if (dl_fall) begin
				loaded_o <= 1'b1;
			end
		end
	end

	// buffer and outgoing word
	always_ff @(posedge clk_cpu) begin
		if (even_wr) begin
			lo_byte <= ioctl_i.data;
		end
		if (odd_wr) begin
			mem[ioctl_i.addr[AW:1]] <= wr_word;
		end
		if (send) begin
			bios_o.addr <= word_addr;
			bios_o.data <= mem[word_addr[AW-1:0]];
		end
	end

endmodule

`default_nettype wire

// ==== src/game_port.sv ====
// game port at 201h; only buttons 0 and 1 of each stick reach the port, the rest are ignored
`timescale 1ns/1ps
`default_nettype none

module game_port
	import setup_pkg::*;
(
	input  wire        clk_cpu,
	input  wire        reset_i,
	input  setup_t     setup_i,
	input  joy_in_t    joy_i,
	input  wire        joy_wr_i,
	output logic [7:0] gpio_o
);

	logic [8:0]  div_cnt;
	logic        tick;
	logic [7:0]  axis_cnt;
	logic [3:0]  axis_q;
	logic [3:0]  btn_q;
	logic [15:0] joy_a;
	logic [15:0] joy_b;
	logic [7:0]  axis_off [4];

	// one tick every (cpu_speed + 1) * 16 cycles
	assign tick = div_cnt >= {setup_i.cpu_speed, 4'hF};

	assign joy_a = setup_i.joy_swap ? joy_i.an1 : joy_i.an0;
	assign joy_b = setup_i.joy_swap ? joy_i.an0 : joy_i.an1;

	// signed axis to unsigned timer count
	always_comb begin
		axis_off[0] = joy_b[15:8] ^ 8'h80;
		axis_off[1] = joy_b[7:0] ^ 8'h80;
		axis_off[2] = joy_a[15:8] ^ 8'h80;
		axis_off[3] = joy_a[7:0] ^ 8'h80;
	end

	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			div_cnt  <= '0;
			axis_cnt <= 8'hFF;
			axis_q   <= '0;
		end else if (joy_wr_i) begin
			// port write fires the one-shots
			div_cnt  <= '0;
			axis_cnt <= '0;
			axis_q   <= 4'hF;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 9'd1;
			if (axis_cnt != 8'hFF) begin
				for (int k = 0; k < 4; k++) begin
					if (axis_cnt == axis_off[k]) begin
						axis_q[k] <= 1'b0;
					end
				end
				if (tick) begin
					axis_cnt <= axis_cnt + 8'd1;
				end
			end else begin
				// timeout, every axis ends
				axis_q <= '0;
			end
		end
	end

	// buttons read back inverted
	always_ff @(posedge clk_cpu) begin
		if (setup_i.joy_swap) begin
			btn_q <= ~{joy_i.btn1[1:0], joy_i.btn0[1:0]};
		end else begin
			btn_q <= ~{joy_i.btn0[1:0], joy_i.btn1[1:0]};
		end
	end

	assign gpio_o = {btn_q, axis_q};

endmodule

`default_nettype wire

// ==== src/cen_gen.sv ====
// fractional clock enable, INC pulses per MOD cycles; INC must be below MOD
`timescale 1ns/1ps
`default_nettype none

module cen_gen #(
	parameter int unsigned INC = 1,
	parameter int unsigned MOD = 2
) (
	input  wire  clk_cpu,
	input  wire  reset_i,
	output logic cen_o
);

	// room for one overshoot past MOD
	localparam int AW = $clog2(2 * MOD);

	logic [AW-1:0] acc;
	logic [AW-1:0] acc_sum;

	assign acc_sum = acc + AW'(INC);

	always_ff @(posedge clk_cpu) begin
		if (reset_i) begin
			acc   <= '0;
			cen_o <= 1'b0;
		end else if (acc_sum >= AW'(MOD)) begin
			// keep the remainder so the rate does not drift
			acc   <= acc_sum - AW'(MOD);
			cen_o <= 1'b1;
		end else begin
			acc   <= acc_sum;
			cen_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/next186_glue.sv ====
// board glue on one clock; BIOS words leave under credits, the ioctl write strobe has no stall
`timescale 1ns/1ps
`default_nettype none

`include "next186_cfg.svh"

module next186_glue
	import setup_pkg::*;
	import xfer_pkg::*;
(
	input  wire         clk_cpu,
	input  wire         reset_i,
	input  status_t     status_i,
	input  ioctl_t      ioctl_i,
	input  wire         bios_credit_i,
	input  joy_in_t     joy_i,
	input  wire         joy_wr_i,
	output setup_t      setup_o,
	output logic        sys_reset_o,
	output bios_out_t   bios_o,
	output logic [15:0] bios_checksum_o,
	output logic [7:0]  gpio_o,
	output logic        cen_opl2_o,
	output logic        cen_audio_o
);

	logic bios_loaded;

	setup_ctrl u_setup_ctrl (
		.clk_cpu     (clk_cpu),
		.reset_i     (reset_i),
		.status_i    (status_i),
		.loaded_i    (bios_loaded),
		.setup_o     (setup_o),
		.sys_reset_o (sys_reset_o)
	);

	bios_loader u_bios_loader (
		.clk_cpu         (clk_cpu),
		.reset_i         (reset_i),
		.ioctl_i         (ioctl_i),
		.bios_credit_i   (bios_credit_i),
		.bios_o          (bios_o),
		.bios_checksum_o (bios_checksum_o),
		.loaded_o        (bios_loaded)
	);

	game_port u_game_port (
		.clk_cpu  (clk_cpu),
		.reset_i  (reset_i),
		.setup_i  (setup_o),
		.joy_i    (joy_i),
		.joy_wr_i (joy_wr_i),
		.gpio_o   (gpio_o)
	);

	// 3.58 MHz FM synth enable
	cen_gen #(
		.INC (`NEXT_OPL2_INC),
		.MOD (`NEXT_CPU_MHZ * 100)
	) u_cen_opl2 (
		.clk_cpu (clk_cpu),
		.reset_i (reset_i),
		.cen_o   (cen_opl2_o)
	);

	// 44.1 kHz sample enable
	cen_gen #(
		.INC (`NEXT_AUDIO_RATE),
		.MOD (`NEXT_CPU_MHZ * 1000000)
	) u_cen_audio (
		.clk_cpu (clk_cpu),
		.reset_i (reset_i),
		.cen_o   (cen_audio_o)
	);

endmodule

`default_nettype wire

// ==== tests/next186_glue_chk.sv ====
// protocol checks bound into next186_glue; the credit count is taken from the BIOS loader
`timescale 1ns/1ps
`default_nettype none

`include "next186_cfg.svh"

module next186_glue_chk #(
	parameter int CW = $clog2(`NEXT_BIOS_CREDITS + 1)
) (
	input wire          clk_cpu,
	input wire          reset_i,
	input wire          valid_i,
	input wire [CW-1:0] credits_i,
	input wire          cen_opl2_i,
	input wire          cen_audio_i,
	input wire [3:0]    axis_i,
	input wire          sys_reset_i
);

	int fail_cnt = 0;

	// no credit this cycle, no word next cycle
	a_credit: assert property (@(posedge clk_cpu) disable iff (reset_i)
		(credits_i == '0) |=> !valid_i)
		else begin
			fail_cnt++;
			$error("BIOS word sent with no credit left");
		end

	a_opl2_pulse: assert property (@(posedge clk_cpu) disable iff (reset_i)
		cen_opl2_i |=> !cen_opl2_i)
		else begin
			fail_cnt++;
			$error("cen_opl2_o high for more than one cycle");
		end

	a_audio_pulse: assert property (@(posedge clk_cpu) disable iff (reset_i)
		cen_audio_i |=> !cen_audio_i)
		else begin
			fail_cnt++;
			$error("cen_audio_o high for more than one cycle");
		end

	a_reset_state: assert property (@(posedge clk_cpu)
		reset_i |=> (!valid_i && !cen_opl2_i && !cen_audio_i && axis_i == 4'h0 && sys_reset_i))
		else begin
			fail_cnt++;
			$error("outputs not in their reset state after reset");
		end

endmodule

bind next186_glue next186_glue_chk u_chk (
	.clk_cpu     (clk_cpu),
	.reset_i     (reset_i),
	.valid_i     (bios_o.valid),
	.credits_i   (u_bios_loader.credits),
	.cen_opl2_i  (cen_opl2_o),
	.cen_audio_i (cen_audio_o),
	.axis_i      (gpio_o[3:0]),
	.sys_reset_i (sys_reset_o)
);

`default_nettype wire

// ==== tests/tb_next186_glue.sv ====
// testbench for the board glue; joystick timing assumes cpu_speed 0, so one tick is 16 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_next186_glue
	import setup_pkg::*;
	import xfer_pkg::*;
();

	localparam int CYCLE_LIMIT = 20000;
	localparam int TICK = 16;
	localparam int WORDS = 64;

	logic        clk_cpu;
	logic        reset_i;
	status_t     status_i;
	ioctl_t      ioctl_i;
	logic        bios_credit_i;
	joy_in_t     joy_i;
	logic        joy_wr_i;
	setup_t      setup_o;
	logic        sys_reset_o;
	bios_out_t   bios_o;
	logic [15:0] bios_checksum_o;
	logic [7:0]  gpio_o;
	logic        cen_opl2_o;
	logic        cen_audio_o;

	logic [15:0] lfsr_q = 16'd54866;
	logic [7:0]  bios_bytes [2 * WORDS];
	int          rx_count = 0;
	int          owed = 0;
	int          cycle_cnt = 0;
	int          mismatch_cnt = 0;
	int          other_cnt = 0;

	next186_glue u_next186_glue (
		.clk_cpu         (clk_cpu),
		.reset_i         (reset_i),
		.status_i        (status_i),
		.ioctl_i         (ioctl_i),
		.bios_credit_i   (bios_credit_i),
		.joy_i           (joy_i),
		.joy_wr_i        (joy_wr_i),
		.setup_o         (setup_o),
		.sys_reset_o     (sys_reset_o),
		.bios_o          (bios_o),
		.bios_checksum_o (bios_checksum_o),
		.gpio_o          (gpio_o),
		.cen_opl2_o      (cen_opl2_o),
		.cen_audio_o     (cen_audio_o)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #4 clk_cpu = ~clk_cpu;
	end

	// fibonacci lfsr with taps 16 14 13 11 and one step per bit
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		logic       fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			r = {r[6:0], fb};
		end
		return r;
	endfunction

	function automatic logic [4:0] speed_divider(input logic [2:0] code);
		case (code)
			3'd1: return 5'd1;
			3'd2: return 5'd2;
			3'd3: return 5'd3;
			3'd4: return 5'd7;
			3'd5: return 5'd15;
			3'd6: return 5'd31;
			default: return 5'd0;
		endcase
	endfunction

	function automatic logic [7:0] isa_wait_cycles(input logic [1:0] code);
		case (code)
			2'd0: return 8'd50;
			2'd1: return 8'd100;
			2'd2: return 8'd166;
			default: return 8'd200;
		endcase
	endfunction

	// bits 3..2 follow the first stick, bits 1..0 the second
	function automatic logic [7:0] axis_offset(input int k, input logic swap);
		logic [15:0] a;
		logic [15:0] b;
		a = swap ? joy_i.an1 : joy_i.an0;
		b = swap ? joy_i.an0 : joy_i.an1;
		case (k)
			0: return b[15:8] ^ 8'h80;
			1: return b[7:0] ^ 8'h80;
			2: return a[15:8] ^ 8'h80;
			default: return a[7:0] ^ 8'h80;
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [31:0] act, input logic [31:0] want);
		assert (act === want) else begin
			mismatch_cnt++;
			$display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, want, act);
		end
	endtask

	task automatic within_range(input string name, input int act, input int lo, input int hi);
		assert (act >= lo && act <= hi) else begin
			mismatch_cnt++;
			$display("MISMATCH t=%0t %s expected=%0d..%0d actual=%0d", $time, name, lo, hi, act);
		end
	endtask

	task automatic finish_run();
		int chk_cnt;
		chk_cnt = u_next186_glue.u_chk.fail_cnt;
		$display("errors: mismatch=%0d other=%0d assertion=%0d", mismatch_cnt, other_cnt, chk_cnt);
		if (mismatch_cnt + other_cnt + chk_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	// all bytes drawn up front and written one per cycle
	task automatic load_bios();
		for (int i = 0; i < 2 * WORDS; i++) begin
			bios_bytes[i] = rand_bits(8);
		end
		@(posedge clk_cpu);
		ioctl_i <= '{download: 1'b1, wr: 1'b0, addr: 7'd0, data: 8'd0};
		for (int i = 0; i < 2 * WORDS; i++) begin
			@(posedge clk_cpu);
			ioctl_i <= '{download: 1'b1, wr: 1'b1, addr: 7'(i), data: bios_bytes[i]};
		end
		@(posedge clk_cpu);
		ioctl_i <= '0;
	endtask

	task automatic button_readback(input logic swap);
		logic [3:0] want;
		@(posedge clk_cpu);
		status_i.joy_swap <= swap;
		repeat (3) @(posedge clk_cpu);
		joy_i.btn0 <= swap ? 4'b0010 : 4'b1101;
		joy_i.btn1 <= swap ? 4'b0011 : 4'b0110;
		@(posedge clk_cpu);
		@(negedge clk_cpu);
		// pressed reads as 0 and the leading stick sits in bits 7..6
		want = swap ? 4'b0001 : 4'b1001;
		compare_value("gpio_o[7:4]", 32'(gpio_o[7:4]), 32'(want));
		compare_value("setup_o.joy_swap", 32'(setup_o.joy_swap), 32'(swap));
	endtask

	// n counts rising edges from the one that drives joy_wr_i
	task automatic sweep_axes(input logic swap);
		int fall [4];
		int n;
		int base;
		fall = '{-1, -1, -1, -1};
		n = 1;
		@(posedge clk_cpu);
		joy_wr_i <= 1'b1;
		@(posedge clk_cpu);
		joy_wr_i <= 1'b0;
		@(negedge clk_cpu);
		compare_value("gpio_o[3:0]", 32'(gpio_o[3:0]), 32'hF);
		while (gpio_o[3:0] != 4'h0 && n < 256 * TICK + 4) begin
			@(posedge clk_cpu);
			n++;
			@(negedge clk_cpu);
			for (int k = 0; k < 4; k++) begin
				if (fall[k] < 0 && !gpio_o[k]) begin
					fall[k] = n;
				end
			end
		end
		for (int k = 0; k < 4; k++) begin
			base = int'(axis_offset(k, swap)) * TICK;
			within_range($sformatf("gpio_o[%0d] fall cycle", k), fall[k], base + 1, base + 2 + TICK);
		end
	endtask

	// consumer takes each word and later gives the credit back
	always @(negedge clk_cpu) begin
		if (bios_o.valid) begin
			assert (rx_count < WORDS) else begin
				other_cnt++;
				$display("BIOS word beyond the last expected one at t=%0t", $time);
			end
			if (rx_count < WORDS) begin
				compare_value("bios_o.addr", 32'(bios_o.addr), 32'(rx_count));
				compare_value("bios_o.data", 32'(bios_o.data.word),
					32'({bios_bytes[2 * rx_count + 1], bios_bytes[2 * rx_count]}));
			end
			rx_count++;
			owed++;
		end
	end

	initial begin
		bios_credit_i <= 1'b0;
		forever begin
			@(posedge clk_cpu);
			if (owed > 0 && rand_bits(2) == 2'd0) begin
				bios_credit_i <= 1'b1;
				owed--;
			end else begin
				bios_credit_i <= 1'b0;
			end
		end
	end

	always @(posedge clk_cpu) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			other_cnt++;
			$display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
			finish_run();
		end
	end

	initial begin
		logic [15:0] sum;
		int          n_opl;
		int          n_aud;
		reset_i  <= 1'b1;
		status_i <= '0;
		ioctl_i  <= '0;
		joy_wr_i <= 1'b0;
		// stick 0 at X 10 Y -50, stick 1 at X -100 Y 60
		joy_i    <= '{btn0: 4'h0, btn1: 4'h0, an0: 16'h0ACE, an1: 16'h9C3C};
		repeat (4) @(posedge clk_cpu);
		reset_i <= 1'b0;

		// every speed code while the wait codes cycle along
		for (int s = 0; s < 8; s++) begin
			status_i.speed    <= 3'(s);
			status_i.isa_wait <= 2'(s);
			@(posedge clk_cpu);
			@(negedge clk_cpu);
			compare_value("setup_o.cpu_speed", 32'(setup_o.cpu_speed),
				32'(speed_divider(3'(s))));
			compare_value("setup_o.wait_states", 32'(setup_o.wait_states),
				32'(isa_wait_cycles(2'(s))));
			compare_value("sys_reset_o", 32'(sys_reset_o), 32'd1);
			@(posedge clk_cpu);
		end
		status_i <= '0;

		load_bios();
		// loaded rises on the next edge and core reset drops one later
		@(posedge clk_cpu);
		@(negedge clk_cpu);
		compare_value("sys_reset_o", 32'(sys_reset_o), 32'd1);
		@(posedge clk_cpu);
		@(negedge clk_cpu);
		compare_value("sys_reset_o", 32'(sys_reset_o), 32'd0);
		@(posedge clk_cpu);
		status_i.reset_req <= 1'b1;
		@(posedge clk_cpu);
		@(negedge clk_cpu);
		compare_value("sys_reset_o", 32'(sys_reset_o), 32'd1);
		@(posedge clk_cpu);
		status_i.reset_req <= 1'b0;

		while (rx_count < WORDS) @(posedge clk_cpu);
		@(negedge clk_cpu);
		sum = '0;
		for (int w = 0; w < WORDS; w++) begin
			sum += {bios_bytes[2 * w + 1], bios_bytes[2 * w]};
		end
		compare_value("bios_checksum_o", 32'(bios_checksum_o), 32'(sum));

		for (int sw = 0; sw < 2; sw++) begin
			button_readback(1'(sw));
			sweep_axes(1'(sw));
		end

		n_opl = 0;
		n_aud = 0;
		repeat (5000) begin
			@(negedge clk_cpu);
			n_opl += int'(cen_opl2_o);
			n_aud += int'(cen_audio_o);
		end
		within_range("cen_opl2_o pulses", n_opl, 357, 359);
		within_range("cen_audio_o pulses", n_aud, 4, 5);

		finish_run();
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/setup_pkg.sv
src/xfer_pkg.sv
src/setup_ctrl.sv
src/bios_loader.sv
src/game_port.sv
src/cen_gen.sv
src/next186_glue.sv
tests/next186_glue_chk.sv
tests/tb_next186_glue.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_next186_glue
FILELIST   := list.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0 -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
